//--- hdl/game_geom_pkg.sv
package game_geom_pkg;

    ////////////////////////////////////////
    // Screen and sprite geometry
    ////////////////////////////////////////
    typedef logic [7:0] x_coord_t;               // Column 0..159
    typedef logic [6:0] y_coord_t;               // Row 0..119

    localparam x_coord_t X_MAX         = 8'd159; // Last column
    localparam y_coord_t Y_MAX         = 7'd119; // Last row
    localparam int       FRUIT_SIZE    = 8;      // Fruit square side
    localparam int       BASKET_SIZE   = 16;     // Basket square side
    localparam x_coord_t BASKET_X_MAX  = 8'd144; // Right limit for a right step
    localparam x_coord_t BASKET_X0     = 8'd72;  // Roughly centred
    localparam y_coord_t BASKET_Y0     = 7'd80;  // Basket never leaves this row
    localparam x_coord_t SPAWN_MIN     = 8'd10;  // Keep spawns off the left edge
    localparam x_coord_t FRUIT2_OFFSET = 8'd10;  // Fruit 2 spawns to the right of fruit 1

    ////////////////////////////////////////
    // Speed timers
    ////////////////////////////////////////
    typedef logic [19:0] period_t;

    localparam period_t FRUIT1_PERIOD0 = 20'd790; // Slowest faller
    localparam period_t FRUIT2_PERIOD0 = 20'd690;
    localparam period_t MOVE_PERIOD0   = 20'd490; // Basket step rate
    localparam period_t PERIOD_STEP    = 20'd5;   // Shrink per period
    localparam period_t PERIOD_MIN     = 20'd100; // Speed ceiling
    localparam period_t FRUIT1_LEAD    = 20'd10;  // Pulse offsets before wrap
    localparam period_t FRUIT2_LEAD    = 20'd20;
    localparam period_t MOVE_LEAD      = 20'd20;

    // Score and lives
    typedef logic [6:0] score_t;
    typedef logic [1:0] lives_t;

    localparam lives_t     LIVES0    = 2'd3;
    localparam score_t     SCORE_MAX = 7'd99;  // Two decimal digits
    localparam logic [7:0] LFSR_SEED = 8'hA5;  // Respawn generator start
    localparam logic [7:0] LFSR_TAPS = 8'hB8;  // Galois feedback mask

endpackage

//--- hdl/draw_pkg.sv
package draw_pkg;

    ////////////////////////////////////////
    // Draw/update loop
    ////////////////////////////////////////
    // Four draw slots then three update slots
    typedef enum logic [2:0] {
        DRAW_BACKGROUND = 3'b111,
        DRAW_FRUIT_1    = 3'b001,
        DRAW_FRUIT_2    = 3'b010,
        DRAW_BASKET     = 3'b100,
        UPDATE_FRUIT_1  = 3'b110,
        UPDATE_FRUIT_2  = 3'b011,
        UPDATE_BASKET   = 3'b101
    } loop_state_t;

    ////////////////////////////////////////
    // Pixel colours
    ////////////////////////////////////////
    typedef logic [2:0] colour_t;                 // One bit per RGB channel

    // One flat colour per layer
    localparam colour_t BG_COLOUR     = 3'b001;   // Blue sky
    localparam colour_t FRUIT1_COLOUR = 3'b110;   // Yellow
    localparam colour_t FRUIT2_COLOUR = 3'b100;   // Red
    localparam colour_t BASKET_COLOUR = 3'b011;   // Cyan

endpackage

//--- hdl/game_if.sv
`timescale 1ns/100ps

// Loop state and object positions shared inside the core
interface game_if;

    draw_pkg::loop_state_t   state;      // Current loop slot

    game_geom_pkg::x_coord_t fruit1_x;   // Top left corner of each sprite
    game_geom_pkg::y_coord_t fruit1_y;
    game_geom_pkg::x_coord_t fruit2_x;
    game_geom_pkg::y_coord_t fruit2_y;
    game_geom_pkg::x_coord_t basket_x;   // Basket row is fixed

    // Loop sequencer
    modport fsm (output state);

    // Position registers live here
    modport state_owner (input state,
                         output fruit1_x, fruit1_y, fruit2_x, fruit2_y, basket_x);

    // Pixel generator only looks
    modport renderer (input state, fruit1_x, fruit1_y, fruit2_x, fruit2_y, basket_x);

endinterface

//--- hdl/frame_fsm.sv
`timescale 1ns/100ps

module frame_fsm (
    input  logic CLOCK_50,
    input  logic KEY,         // Active low reset
    game_if.fsm  bus
);

    draw_pkg::loop_state_t state_q;
    draw_pkg::loop_state_t state_d;

    ////////////////////////////////////////
    // Next state
    ////////////////////////////////////////
    // Fixed ring, one slot per clock
    always_comb begin
        case (state_q)
            draw_pkg::DRAW_BACKGROUND: state_d = draw_pkg::DRAW_FRUIT_1;
            draw_pkg::DRAW_FRUIT_1:    state_d = draw_pkg::DRAW_FRUIT_2;
            draw_pkg::DRAW_FRUIT_2:    state_d = draw_pkg::DRAW_BASKET;
            draw_pkg::DRAW_BASKET:     state_d = draw_pkg::UPDATE_FRUIT_1;
            draw_pkg::UPDATE_FRUIT_1:  state_d = draw_pkg::UPDATE_FRUIT_2;
            draw_pkg::UPDATE_FRUIT_2:  state_d = draw_pkg::UPDATE_BASKET;
            draw_pkg::UPDATE_BASKET:   state_d = draw_pkg::DRAW_BACKGROUND; // Close the loop
            default:                   state_d = draw_pkg::DRAW_BACKGROUND; // Stray encoding
        endcase
    end

    ////////////////////////////////////////
    // State register
    ////////////////////////////////////////
    always_ff @(posedge CLOCK_50 or negedge KEY) begin
        if (!KEY) begin
            state_q <= draw_pkg::DRAW_BACKGROUND;
        end else begin
            state_q <= state_d;
        end
    end

    assign bus.state = state_q;

endmodule

//--- hdl/speed_timers.sv
`timescale 1ns/100ps

module speed_timers (
    input  logic CLOCK_50,
    input  logic KEY,           // Active low reset
    output logic fall1_pulse,   // Fruit 1 drop request
    output logic fall2_pulse,   // Fruit 2 drop request
    output logic move_pulse     // Basket step request
);

    // Index 0 fruit 1, index 1 fruit 2, index 2 basket
    game_geom_pkg::period_t count_q  [3];
    game_geom_pkg::period_t period_q [3];   // Shrinks every wrap
    game_geom_pkg::period_t lead     [3];
    logic [2:0]             sync;

    assign lead[0] = game_geom_pkg::FRUIT1_LEAD;
    assign lead[1] = game_geom_pkg::FRUIT2_LEAD;
    assign lead[2] = game_geom_pkg::MOVE_LEAD;

    ////////////////////////////////////////
    // Counters and shrinking periods
    ////////////////////////////////////////
    always_ff @(posedge CLOCK_50 or negedge KEY) begin
        if (!KEY) begin
            for (int i = 0; i < 3; i++) begin
                count_q[i] <= '0;
            end
            period_q[0] <= game_geom_pkg::FRUIT1_PERIOD0;
            period_q[1] <= game_geom_pkg::FRUIT2_PERIOD0;
            period_q[2] <= game_geom_pkg::MOVE_PERIOD0;
        end else begin
            for (int i = 0; i < 3; i++) begin
                if (count_q[i] == period_q[i]) begin
                    count_q[i] <= '0;   // Wrap and speed up
                    if (period_q[i] >= game_geom_pkg::PERIOD_MIN + game_geom_pkg::PERIOD_STEP)
                        period_q[i] <= period_q[i] - game_geom_pkg::PERIOD_STEP;
                    else
                        period_q[i] <= game_geom_pkg::PERIOD_MIN; // Clamp at the floor
                end else begin
                    count_q[i] <= count_q[i] + 1'b1;
                end
            end
        end
    end

    // Staggered sync, one cycle each, a lead before the wrap
    always_comb begin
        for (int i = 0; i < 3; i++) begin
            sync[i] = (count_q[i] == period_q[i] - lead[i]);
        end
    end

    assign fall1_pulse = sync[0];
    assign fall2_pulse = sync[1];
    assign move_pulse  = sync[2];

endmodule

//--- hdl/game_state.sv
`timescale 1ns/100ps

module game_state (
    input  logic                  CLOCK_50,
    input  logic                  KEY,          // Active low reset
    input  logic                  left,         // Held to move left
    input  logic                  right,        // Held to move right
    input  logic                  fall1_pulse,
    input  logic                  fall2_pulse,
    input  logic                  move_pulse,
    game_if.state_owner           bus,
    output game_geom_pkg::score_t score,
    output game_geom_pkg::lives_t lives,
    output logic                  game_over
);

    game_geom_pkg::x_coord_t fruit1_x_q;
    game_geom_pkg::y_coord_t fruit1_y_q;
    game_geom_pkg::x_coord_t fruit2_x_q;
    game_geom_pkg::y_coord_t fruit2_y_q;
    game_geom_pkg::x_coord_t basket_x_q;
    logic [2:0]              pend_q;     // Fruit 1, fruit 2, basket
    logic [2:0]              want;       // Held or arriving this cycle
    logic [7:0]              lfsr_q;
    logic [7:0]              lfsr_next;
    game_geom_pkg::x_coord_t spawn_x;    // Fruit 1 column after a respawn

    logic                    serve1;
    logic                    serve2;
    logic                    serve_b;
    game_geom_pkg::x_coord_t cur_x;      // Fruit in its update slot
    game_geom_pkg::y_coord_t cur_y;
    logic                    caught;
    logic                    missed;
    logic                    respawn;

    // Keep spawns off the left edge
    function automatic game_geom_pkg::x_coord_t spawn_col(input logic [7:0] v);
        return (v > game_geom_pkg::SPAWN_MIN) ? v : v + game_geom_pkg::SPAWN_MIN;
    endfunction

    // Square boxes sharing any pixel, one spare bit against wrap
    function automatic logic overlaps(input game_geom_pkg::x_coord_t fx,
                                      input game_geom_pkg::y_coord_t fy,
                                      input game_geom_pkg::x_coord_t bx);
        logic [8:0] fx_w;
        logic [8:0] bx_w;
        logic [7:0] fy_w;
        logic [7:0] by_w;
        fx_w = {1'b0, fx};
        bx_w = {1'b0, bx};
        fy_w = {1'b0, fy};
        by_w = {1'b0, game_geom_pkg::BASKET_Y0};
        return (fx_w < bx_w + 9'(game_geom_pkg::BASKET_SIZE))
            && (bx_w < fx_w + 9'(game_geom_pkg::FRUIT_SIZE))
            && (fy_w < by_w + 8'(game_geom_pkg::BASKET_SIZE))
            && (by_w < fy_w + 8'(game_geom_pkg::FRUIT_SIZE));
    endfunction

    ////////////////////////////////////////
    // Slot decode
    ////////////////////////////////////////
    assign want      = pend_q | {move_pulse, fall2_pulse, fall1_pulse};
    assign game_over = (lives == '0);   // Freezes every update

    assign serve1  = !game_over && want[0] && (bus.state == draw_pkg::UPDATE_FRUIT_1);
    assign serve2  = !game_over && want[1] && (bus.state == draw_pkg::UPDATE_FRUIT_2);
    assign serve_b = !game_over && want[2] && (bus.state == draw_pkg::UPDATE_BASKET);

    // Only one fruit slot at a time
    assign cur_x   = serve2 ? fruit2_x_q : fruit1_x_q;
    assign cur_y   = serve2 ? fruit2_y_q : fruit1_y_q;
    assign caught  = (serve1 || serve2) && overlaps(cur_x, cur_y, basket_x_q);
    assign missed  = (serve1 || serve2) && !caught && (cur_y >= game_geom_pkg::Y_MAX);
    assign respawn = caught || missed;

    // Galois step
    assign lfsr_next = lfsr_q[0] ? ((lfsr_q >> 1) ^ game_geom_pkg::LFSR_TAPS) : (lfsr_q >> 1);
    assign spawn_x   = spawn_col(lfsr_next);

    ////////////////////////////////////////
    // Positions, score and lives
    ////////////////////////////////////////
    always_ff @(posedge CLOCK_50 or negedge KEY) begin
        if (!KEY) begin
            fruit1_x_q <= spawn_col(game_geom_pkg::LFSR_SEED);
            fruit1_y_q <= '0;
            fruit2_x_q <= spawn_col(game_geom_pkg::LFSR_SEED) + game_geom_pkg::FRUIT2_OFFSET;
            fruit2_y_q <= '0;
            basket_x_q <= game_geom_pkg::BASKET_X0;
            pend_q     <= '0;
            lfsr_q     <= game_geom_pkg::LFSR_SEED;
            score      <= '0;
            lives      <= game_geom_pkg::LIVES0;
        end else begin
            pend_q <= want;                              // Repeats are absorbed
            if (caught && score < game_geom_pkg::SCORE_MAX) begin
                score <= score + 1'b1;
            end
            if (missed) begin
                lives <= lives - 1'b1;
            end
            if (respawn) begin
                lfsr_q <= lfsr_next;                     // One step per respawn
            end
            if (serve1) begin
                pend_q[0]  <= 1'b0;
                fruit1_x_q <= respawn ? spawn_x : fruit1_x_q;
                fruit1_y_q <= respawn ? 7'd1 : fruit1_y_q + 1'b1;
            end
            if (serve2) begin
                pend_q[1]  <= 1'b0;
                fruit2_x_q <= respawn ? spawn_x + game_geom_pkg::FRUIT2_OFFSET : fruit2_x_q;
                fruit2_y_q <= respawn ? 7'd3 : fruit2_y_q + 1'b1;  // Staggered from fruit 1
            end
            if (serve_b) begin
                pend_q[2] <= 1'b0;
                if (right && basket_x_q <= game_geom_pkg::BASKET_X_MAX) begin
                    basket_x_q <= basket_x_q + 1'b1;
                end else if (left && basket_x_q != '0) begin
                    basket_x_q <= basket_x_q - 1'b1;
                end
            end
        end
    end

    assign bus.fruit1_x = fruit1_x_q;
    assign bus.fruit1_y = fruit1_y_q;
    assign bus.fruit2_x = fruit2_x_q;
    assign bus.fruit2_y = fruit2_y_q;
    assign bus.basket_x = basket_x_q;

endmodule

//--- hdl/pixel_scan.sv
`timescale 1ns/100ps

module pixel_scan (
    input  logic                     CLOCK_50,
    input  logic                     KEY,        // Active low reset
    game_if.renderer                 bus,
    output game_geom_pkg::x_coord_t  pix_x,
    output game_geom_pkg::y_coord_t  pix_y,
    output draw_pkg::colour_t        pix_colour,
    output logic                     plot
);

    game_geom_pkg::x_coord_t bg_x;       // Background raster position
    game_geom_pkg::y_coord_t bg_y;
    logic [5:0]              fruit1_off; // {row, col} inside 8x8
    logic [5:0]              fruit2_off;
    logic [7:0]              basket_off; // {row, col} inside 16x16

    game_geom_pkg::x_coord_t x_d;
    game_geom_pkg::y_coord_t y_d;
    draw_pkg::colour_t       colour_d;
    logic                    draw_d;

    ////////////////////////////////////////
    // Raster counters
    ////////////////////////////////////////
    always_ff @(posedge CLOCK_50 or negedge KEY) begin
        if (!KEY) begin
            bg_x       <= '0;
            bg_y       <= '0;
            fruit1_off <= '0;
            fruit2_off <= '0;
            basket_off <= '0;
        end else begin
            case (bus.state)
                draw_pkg::DRAW_BACKGROUND: begin
                    if (bg_x == game_geom_pkg::X_MAX) begin
                        bg_x <= '0;
                        bg_y <= (bg_y == game_geom_pkg::Y_MAX) ? '0 : bg_y + 1'b1; // Next row
                    end else begin
                        bg_x <= bg_x + 1'b1;
                    end
                end
                // Column bits carry into row bits
                draw_pkg::DRAW_FRUIT_1: fruit1_off <= fruit1_off + 1'b1;
                draw_pkg::DRAW_FRUIT_2: fruit2_off <= fruit2_off + 1'b1;
                draw_pkg::DRAW_BASKET:  basket_off <= basket_off + 1'b1;
                default: ;                                 // Update slots leave them alone
            endcase
        end
    end

    ////////////////////////////////////////
    // Layer select
    ////////////////////////////////////////
    always_comb begin
        x_d      = bg_x;
        y_d      = bg_y;
        colour_d = draw_pkg::BG_COLOUR;
        draw_d   = 1'b1;
        case (bus.state)
            draw_pkg::DRAW_BACKGROUND: ;                   // Defaults above
            draw_pkg::DRAW_FRUIT_1: begin
                x_d      = bus.fruit1_x + game_geom_pkg::x_coord_t'(fruit1_off[2:0]);
                y_d      = bus.fruit1_y + game_geom_pkg::y_coord_t'(fruit1_off[5:3]);
                colour_d = draw_pkg::FRUIT1_COLOUR;
            end
            draw_pkg::DRAW_FRUIT_2: begin
                x_d      = bus.fruit2_x + game_geom_pkg::x_coord_t'(fruit2_off[2:0]);
                y_d      = bus.fruit2_y + game_geom_pkg::y_coord_t'(fruit2_off[5:3]);
                colour_d = draw_pkg::FRUIT2_COLOUR;
            end
            draw_pkg::DRAW_BASKET: begin
                x_d      = bus.basket_x + game_geom_pkg::x_coord_t'(basket_off[3:0]);
                y_d      = game_geom_pkg::BASKET_Y0 + game_geom_pkg::y_coord_t'(basket_off[7:4]);
                colour_d = draw_pkg::BASKET_COLOUR;
            end
            default: draw_d = 1'b0;                        // No pixel in update slots
        endcase
    end

    // Output stage
    always_ff @(posedge CLOCK_50 or negedge KEY) begin
        if (!KEY) begin
            plot <= 1'b0;
        end else begin
            plot <= draw_d;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        pix_x      <= x_d;
        pix_y      <= y_d;
        pix_colour <= colour_d;
    end

endmodule

//--- hdl/seg_display.sv
`timescale 1ns/100ps

module seg_display (
    input  game_geom_pkg::score_t score,
    input  game_geom_pkg::lives_t lives,
    output logic [6:0]            hex_tens,   // Active low segments
    output logic [6:0]            hex_units,
    output logic [6:0]            hex_lives
);

    logic [3:0] tens;
    logic [3:0] units;

    ////////////////////////////////////////
    // Digit table, segment 0 in bit 0
    ////////////////////////////////////////
    function automatic logic [6:0] digit_seg(input logic [3:0] d);
        case (d)
            4'd0:    return 7'b1000000;
            4'd1:    return 7'b1111001;
            4'd2:    return 7'b0100100;
            4'd3:    return 7'b0110000;
            4'd4:    return 7'b0011001;
            4'd5:    return 7'b0010010;
            4'd6:    return 7'b0000010;
            4'd7:    return 7'b1111000;
            4'd8:    return 7'b0000000;
            4'd9:    return 7'b0011000;
            default: return 7'b1111111;   // Blank
        endcase
    endfunction

    // Score never passes 99 so tens fits one digit
    assign tens  = 4'(score / 7'd10);
    assign units = 4'(score % 7'd10);

    assign hex_tens  = digit_seg(tens);
    assign hex_units = digit_seg(units);
    assign hex_lives = digit_seg({2'b00, lives});

endmodule

//--- hdl/fruit_game.sv
`timescale 1ns/100ps

module fruit_game (
    input  logic                    CLOCK_50,
    input  logic                    KEY,          // Active low reset
    input  logic                    left,
    input  logic                    right,
    output logic [6:0]              HEX0,         // Lives
    output logic [6:0]              HEX4,         // Score units
    output logic [6:0]              HEX5,         // Score tens
    output game_geom_pkg::x_coord_t pix_x,
    output game_geom_pkg::y_coord_t pix_y,
    output draw_pkg::colour_t       pix_colour,
    output logic                    plot,
    output logic                    game_over
);

    logic                  fall1_pulse;
    logic                  fall2_pulse;
    logic                  move_pulse;
    game_geom_pkg::score_t score;
    game_geom_pkg::lives_t lives;

    game_if bus ();

    ////////////////////////////////////////
    // Loop and timing
    ////////////////////////////////////////
    frame_fsm u_fsm (
        .CLOCK_50 (CLOCK_50),
        .KEY      (KEY),
        .bus      (bus.fsm)
    );

    speed_timers u_timers (
        .CLOCK_50    (CLOCK_50),
        .KEY         (KEY),
        .fall1_pulse (fall1_pulse),
        .fall2_pulse (fall2_pulse),
        .move_pulse  (move_pulse)
    );

    ////////////////////////////////////////
    // Game rules
    ////////////////////////////////////////
    game_state u_state (
        .CLOCK_50    (CLOCK_50),
        .KEY         (KEY),
        .left        (left),
        .right       (right),
        .fall1_pulse (fall1_pulse),
        .fall2_pulse (fall2_pulse),
        .move_pulse  (move_pulse),
        .bus         (bus.state_owner),
        .score       (score),
        .lives       (lives),
        .game_over   (game_over)
    );

    // Pixel stream and digits
    pixel_scan u_scan (
        .CLOCK_50   (CLOCK_50),
        .KEY        (KEY),
        .bus        (bus.renderer),
        .pix_x      (pix_x),
        .pix_y      (pix_y),
        .pix_colour (pix_colour),
        .plot       (plot)
    );

    seg_display u_seg (
        .score     (score),
        .lives     (lives),
        .hex_tens  (HEX5),
        .hex_units (HEX4),
        .hex_lives (HEX0)
    );

endmodule

//--- dv/tb_fruit_game.sv
`timescale 1ns/100ps

module tb_fruit_game;

    logic       CLOCK_50;
    logic       KEY;
    logic       left;
    logic       right;
    logic [6:0] HEX0;
    logic [6:0] HEX4;
    logic [6:0] HEX5;
    logic [7:0] pix_x;
    logic [6:0] pix_y;
    logic [2:0] pix_colour;
    logic       plot;
    logic       game_over;

    // Case table
    int c_left[$];
    int c_right[$];
    int c_cycles[$];
    int c_score[$];
    int c_lives[$];
    int c_bx[$];
    int total_cycles = 0;
    bit loaded       = 0;

    // Reference model, loop slot 0..6 in draw/update order
    int st;
    int cnt[3];
    int per[3];
    int lead[3] = '{10, 20, 20};
    bit pend[3];
    int f1x, f1y, f2x, f2y, bx;
    int lfsr;
    int score_m, lives_m;
    bit over_m;
    int bgx, bgy, off1, off2, offb;
    int exp_x, exp_y, exp_col;
    bit exp_plot;

    fruit_game UUT (.*);

    initial begin
        CLOCK_50 = 1'b0;
        forever #4 CLOCK_50 = ~CLOCK_50;  // 8 ns period
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////
    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error: %s got %h expected %h", name, got, exp);
            $display("SOME TESTS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // Active low digit pattern, segment a in bit 0
    function automatic logic [6:0] seg_of(input int d);
        logic [6:0] s;
        case (d)
            0: s = 7'h40;
            1: s = 7'h79;
            2: s = 7'h24;
            3: s = 7'h30;
            4: s = 7'h19;
            5: s = 7'h12;
            6: s = 7'h02;
            7: s = 7'h78;
            8: s = 7'h00;
            9: s = 7'h18;
            default: s = 7'h7f;
        endcase
        return s;
    endfunction

    function automatic bit boxes_touch(input int fx, input int fy);
        return (fx < bx + 16) && (bx < fx + 8) && (fy < 80 + 16) && (80 < fy + 8);
    endfunction

    // Galois step, then keep the spawn off the left edge
    task automatic respawn(input int which, output int x, output int y);
        int v;
        lfsr = (lfsr & 1) ? ((lfsr >> 1) ^ 8'hB8) : (lfsr >> 1);
        v = (lfsr > 10) ? lfsr : ((lfsr + 10) & 255);
        x = (which == 1) ? v : ((v + 10) & 255);
        y = (which == 1) ? 1 : 3;
    endtask

    task automatic fruit_step(input int which, inout int x, inout int y);
        if (boxes_touch(x, y)) begin
            if (score_m < 99) score_m++;                  // Caught
            respawn(which, x, y);
        end else if (y >= 119) begin
            lives_m--;                                    // Missed
            respawn(which, x, y);
        end else begin
            y++;
        end
    endtask

    task automatic model_reset();
        st = 0;
        cnt = '{0, 0, 0};
        per = '{790, 690, 490};
        pend = '{0, 0, 0};
        lfsr = 8'hA5;
        f1x = 8'hA5;                                     // Seed above the minimum
        f2x = (8'hA5 + 10) & 255;
        f1y = 0;
        f2y = 0;
        bx = 72;
        score_m = 0;
        lives_m = 3;
        over_m = 0;
        bgx = 0;
        bgy = 0;
        off1 = 0;
        off2 = 0;
        offb = 0;
        exp_plot = 0;
    endtask

    ////////////////////////////////////////
    // Cycle model
    ////////////////////////////////////////
    always @(posedge CLOCK_50 or negedge KEY) begin
        bit pulse[3];
        bit eff;
        if (!KEY) begin
            model_reset();
        end else begin
            for (int i = 0; i < 3; i++) begin
                pulse[i] = (cnt[i] == per[i] - lead[i]);
                if (cnt[i] == per[i]) begin
                    cnt[i] = 0;
                    per[i] = (per[i] >= 105) ? per[i] - 5 : 100;
                end else begin
                    cnt[i]++;
                end
            end
            // Pixel from pre-edge positions
            exp_plot = (st < 4);
            case (st)
                0: begin
                    exp_x = bgx;
                    exp_y = bgy;
                    exp_col = 3'b001;
                    if (bgx == 159) begin
                        bgx = 0;
                        bgy = (bgy == 119) ? 0 : bgy + 1;
                    end else bgx++;
                end
                1: begin
                    exp_x = (f1x + off1 % 8) & 255;
                    exp_y = (f1y + off1 / 8) & 127;
                    exp_col = 3'b110;
                    off1 = (off1 + 1) % 64;
                end
                2: begin
                    exp_x = (f2x + off2 % 8) & 255;
                    exp_y = (f2y + off2 / 8) & 127;
                    exp_col = 3'b100;
                    off2 = (off2 + 1) % 64;
                end
                3: begin
                    exp_x = (bx + offb % 16) & 255;
                    exp_y = 80 + offb / 16;
                    exp_col = 3'b011;
                    offb = (offb + 1) % 256;
                end
                default: ;
            endcase
            // Pending slots, slot index 4+i serves object i
            for (int i = 0; i < 3; i++) begin
                eff = pend[i] | pulse[i];
                if (st == 4 + i && eff && !over_m) begin
                    pend[i] = 0;
                    if (i == 0) fruit_step(1, f1x, f1y);
                    else if (i == 1) fruit_step(2, f2x, f2y);
                    else if (right && bx <= 144) bx++;
                    else if (left && bx > 0) bx--;
                end else begin
                    pend[i] = eff;
                end
            end
            over_m = (lives_m == 0);
            st = (st + 1) % 7;
        end
    end

    // Outputs are settled on the falling edge
    always @(negedge CLOCK_50) begin
        if (KEY) begin
            check("plot", plot, exp_plot);
            check("game_over", game_over, over_m);
            check("HEX0", HEX0, seg_of(lives_m));
            check("HEX5", HEX5, seg_of(score_m / 10));
            check("HEX4", HEX4, seg_of(score_m % 10));
            if (exp_plot) begin
                check("pix_x", pix_x, exp_x);
                check("pix_y", pix_y, exp_y);
                check("pix_colour", pix_colour, exp_col);
            end
        end
    end

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////
    initial begin
        int fd;
        int n;
        int a, b, c, d, e, f;
        string line;
        KEY = 1'b0;
        left = 1'b0;
        right = 1'b0;
        fd = $fopen("dv/fruit_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open the case file");
            $display("SOME TESTS FAILED");
            $fatal(1, "no case file");
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 1 && line[0] != "#") begin
                if ($sscanf(line, "%d %d %d %d %d %d", a, b, c, d, e, f) == 6) begin
                    c_left.push_back(a);
                    c_right.push_back(b);
                    c_cycles.push_back(c);
                    c_score.push_back(d);
                    c_lives.push_back(e);
                    c_bx.push_back(f);
                    total_cycles += c;
                end
            end
        end
        $fclose(fd);
        loaded = 1;
        repeat (8) @(posedge CLOCK_50);
        @(negedge CLOCK_50);
        KEY = 1'b1;
        for (int k = 0; k < c_cycles.size(); k++) begin
            @(negedge CLOCK_50);
            left = c_left[k][0];
            right = c_right[k][0];
            repeat (c_cycles[k]) @(posedge CLOCK_50);
            @(negedge CLOCK_50);
            check("score", score_m, c_score[k]);
            check("lives", lives_m, c_lives[k]);
            check("basket_x", bx, c_bx[k]);
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

    // Watchdog, case lengths plus a tenth
    initial begin
        wait (loaded);
        #((total_cycles + total_cycles / 10 + 100) * 8);
        $display("The run timed out before all cases finished");
        $display("SOME TESTS FAILED");
        $fatal(1, "timeout");
    end

endmodule

//--- dv/fruit_cases.txt
# left right cycles score lives basket_x
# Decimal values, each case continues from the previous one
0 1 700 0 3 73
0 1 1000 0 3 75
1 0 1300 0 3 72
0 0 2000 0 3 72
1 0 25000 0 3 0
0 1 16000 0 3 145

//--- list.f
hdl/game_geom_pkg.sv
hdl/draw_pkg.sv
hdl/game_if.sv
hdl/frame_fsm.sv
hdl/speed_timers.sv
hdl/game_state.sv
hdl/pixel_scan.sv
hdl/seg_display.sv
hdl/fruit_game.sv
dv/tb_fruit_game.sv

//--- Bender.yml
package:
  name: fruit_game

sources:
  - hdl/game_geom_pkg.sv
  - hdl/draw_pkg.sv
  - hdl/game_if.sv
  - hdl/frame_fsm.sv
  - hdl/speed_timers.sv
  - hdl/game_state.sv
  - hdl/pixel_scan.sv
  - hdl/seg_display.sv
  - hdl/fruit_game.sv
  - target: test
    files:
      - dv/tb_fruit_game.sv
